/* Bender.yml */
package:
  name: rate_servo

sources:
  - common/servo_pkg.sv
  - design/rate_reg_slave.sv
  - servo_loop/loop_sequencer.sv
  - servo_loop/trig_bus_master.sv
  - servo_loop/threshold_calc.sv
  - design/rate_servo_top.sv
  - target: simulation
    files:
      - tb/trig_core_model.sv
      - tb/tb_rate_servo.sv

/* common/servo_pkg.sv */
package servo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int ADDR_W   = 22;                   // Both Wishbone buses
    localparam int DATA_W   = 32;
    localparam int THRESH_W = 18;                   // Core threshold field

    localparam logic [THRESH_W-1:0] START_THRESH = 18'd3500;  // Loaded at reset

    ////////////////////////////////////////////////////////////////////////////
    // Trigger core address map and commands
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [ADDR_W-1:0] CORE_CMD_ADDR    = 22'h000;  // Command / status
    localparam logic [ADDR_W-1:0] CORE_THRESH_BASE = 22'h100;  // Threshold wr, count rd
    localparam logic [ADDR_W-1:0] CORE_CE_BASE     = 22'h200;  // Per-beam enable strobes

    localparam logic [DATA_W-1:0] CMD_START_COUNT = 32'd1;     // Status bit 0 = window done
    localparam logic [DATA_W-1:0] CMD_APPLY       = 32'd2;     // Apply pending thresholds

    localparam int BOOT_CYCLES = 31;                // Idle time before first writes

    // Control loop states
    typedef enum logic [2:0] {
        BOOT,
        POLL,          // Start count window
        WAIT_DONE,     // Poll status until window done
        READ_COUNTS,
        CALC,
        WRITE_THRESH,
        ENABLE,        // Per-beam CE writes
        APPLY
    } servo_state_e;

    // Software slave states
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        ACK
    } slave_state_e;

    // Slave register decode
    typedef enum logic [2:0] {
        REG_COUNT,     // Address bit 8
        REG_THRESH,    // Address bit 9
        REG_KP,        // Offset 0
        REG_TARGET,    // Offset 4
        REG_NONE
    } reg_sel_e;

endpackage

/* design/rate_reg_slave.sv */
`timescale 1ns/1ps

module rate_reg_slave #(
    parameter int NBEAMS       = 2,
    parameter int START_TARGET = 100,
    parameter int START_KP     = 1
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [servo_pkg::ADDR_W-1:0]    wb_adr_i,
    input  logic [servo_pkg::DATA_W-1:0]    wb_dat_i,
    output logic                            wb_ack_o,
    output logic [servo_pkg::DATA_W-1:0]    wb_dat_o,
    output logic [7:0]                      rd_idx_o,
    input  logic [servo_pkg::DATA_W-1:0]    count_rd_i,
    input  logic [servo_pkg::THRESH_W-1:0]  thresh_rd_i,
    output logic [servo_pkg::DATA_W-1:0]    kp_o,
    output logic [servo_pkg::DATA_W-1:0]    target_o
);

    servo_pkg::slave_state_e         state;
    servo_pkg::reg_sel_e             sel;
    logic                            idx_ok;    // Beam index in range
    logic [servo_pkg::DATA_W-1:0]    rd_val;

    assign rd_idx_o = wb_adr_i[7:0];            // Beam select for counts/thresholds
    assign idx_ok   = (rd_idx_o < NBEAMS);
    assign wb_ack_o = (state == servo_pkg::ACK);

    // Address decode, counts win over thresholds
    always_comb begin
        if (wb_adr_i[8])                 sel = servo_pkg::REG_COUNT;
        else if (wb_adr_i[9])            sel = servo_pkg::REG_THRESH;
        else if (wb_adr_i[7:0] == 8'h00) sel = servo_pkg::REG_KP;
        else if (wb_adr_i[7:0] == 8'h04) sel = servo_pkg::REG_TARGET;
        else                             sel = servo_pkg::REG_NONE;
    end

    always_comb begin
        case (sel)
            servo_pkg::REG_COUNT:  rd_val = idx_ok ? count_rd_i : '0;
            servo_pkg::REG_THRESH: rd_val = idx_ok ? servo_pkg::DATA_W'(thresh_rd_i) : '0;
            servo_pkg::REG_KP:     rd_val = kp_o;
            servo_pkg::REG_TARGET: rd_val = target_o;
            default:               rd_val = '0;     // Unmapped reads as zero
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fixed-latency slave FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state    <= servo_pkg::IDLE;
            kp_o     <= servo_pkg::DATA_W'(START_KP);
            target_o <= servo_pkg::DATA_W'(START_TARGET);
        end else begin
            case (state)
                servo_pkg::IDLE:
                    if (wb_cyc_i && wb_stb_i)
                        state <= wb_we_i ? servo_pkg::WRITE : servo_pkg::READ;
                servo_pkg::WRITE: begin
                    state <= servo_pkg::ACK;
                    if (sel == servo_pkg::REG_KP)     kp_o     <= wb_dat_i;
                    if (sel == servo_pkg::REG_TARGET) target_o <= wb_dat_i;
                end
                servo_pkg::READ: state <= servo_pkg::ACK;
                default:         state <= servo_pkg::IDLE;   // ACK lasts one cycle
            endcase
        end
    end

    // Read data, sampled while the master still holds the address
    always_ff @(posedge wb_clk_i) begin
        if (state == servo_pkg::READ) wb_dat_o <= rd_val;
    end

    // Decode works on the live address, so the master holds its request until ack
    req_held: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        (state == servo_pkg::WRITE || state == servo_pkg::READ) |->
            wb_cyc_i && wb_stb_i && $stable(wb_adr_i));

endmodule

/* design/rate_servo_top.sv */
`timescale 1ns/1ps

module rate_servo_top #(
    parameter int NBEAMS       = 2,
    parameter int COUNT_MARGIN = 10,
    parameter int START_TARGET = 100,
    parameter int START_KP     = 1
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    // Software slave bus
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [servo_pkg::ADDR_W-1:0]    wb_adr_i,
    input  logic [servo_pkg::DATA_W-1:0]    wb_dat_i,
    output logic                            wb_ack_o,
    output logic [servo_pkg::DATA_W-1:0]    wb_dat_o,
    // Trigger core master bus
    output logic                            core_cyc_o,
    output logic                            core_stb_o,
    output logic                            core_we_o,
    output logic [servo_pkg::ADDR_W-1:0]    core_adr_o,
    output logic [servo_pkg::DATA_W-1:0]    core_dat_o,
    input  logic                            core_ack_i,
    input  logic [servo_pkg::DATA_W-1:0]    core_dat_i
);

    logic                            req, req_we, done;
    logic [servo_pkg::ADDR_W-1:0]    req_adr;
    logic [servo_pkg::DATA_W-1:0]    req_dat, rd_data, count, count_rd, kp, target;
    logic [7:0]                      beam_idx, rd_idx;
    logic                            count_wr, calc_start, calc_done, commit;
    logic [servo_pkg::THRESH_W-1:0]  new_thresh, thresh_rd;

    ////////////////////////////////////////////////////////////////////////////
    // Software side
    ////////////////////////////////////////////////////////////////////////////
    rate_reg_slave #(.NBEAMS(NBEAMS), .START_TARGET(START_TARGET), .START_KP(START_KP))
    u_slave (
        .wb_clk_i, .rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_ack_o, .wb_dat_o, .rd_idx_o(rd_idx), .count_rd_i(count_rd),
        .thresh_rd_i(thresh_rd), .kp_o(kp), .target_o(target)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Servo loop toward the core
    ////////////////////////////////////////////////////////////////////////////
    loop_sequencer #(.NBEAMS(NBEAMS)) u_seq (
        .wb_clk_i, .rst_i, .req_o(req), .req_we_o(req_we), .req_adr_o(req_adr),
        .req_dat_o(req_dat), .done_i(done), .rd_data_i(rd_data), .beam_idx_o(beam_idx),
        .count_wr_o(count_wr), .count_o(count), .calc_start_o(calc_start),
        .commit_o(commit), .calc_done_i(calc_done), .new_thresh_i(new_thresh)
    );

    trig_bus_master u_master (
        .wb_clk_i, .rst_i, .req_i(req), .req_we_i(req_we), .req_adr_i(req_adr),
        .req_dat_i(req_dat), .done_o(done), .rd_data_o(rd_data), .core_cyc_o,
        .core_stb_o, .core_we_o, .core_adr_o, .core_dat_o, .core_ack_i, .core_dat_i
    );

    threshold_calc #(.NBEAMS(NBEAMS), .COUNT_MARGIN(COUNT_MARGIN)) u_calc (
        .wb_clk_i, .rst_i, .beam_idx_i(beam_idx), .count_wr_i(count_wr), .count_i(count),
        .calc_start_i(calc_start), .commit_i(commit), .kp_i(kp), .target_i(target),
        .rd_idx_i(rd_idx), .calc_done_o(calc_done), .new_thresh_o(new_thresh),
        .count_rd_o(count_rd), .thresh_rd_o(thresh_rd)
    );

endmodule

/* files.f */
common/servo_pkg.sv
design/rate_reg_slave.sv
servo_loop/loop_sequencer.sv
servo_loop/trig_bus_master.sv
servo_loop/threshold_calc.sv
design/rate_servo_top.sv
tb/trig_core_model.sv
tb/tb_rate_servo.sv

/* servo_loop/loop_sequencer.sv */
`timescale 1ns/1ps

module loop_sequencer #(
    parameter int NBEAMS = 2
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    output logic                            req_o,
    output logic                            req_we_o,
    output logic [servo_pkg::ADDR_W-1:0]    req_adr_o,
    output logic [servo_pkg::DATA_W-1:0]    req_dat_o,
    input  logic                            done_i,
    input  logic [servo_pkg::DATA_W-1:0]    rd_data_i,
    output logic [7:0]                      beam_idx_o,
    output logic                            count_wr_o,
    output logic [servo_pkg::DATA_W-1:0]    count_o,
    output logic                            calc_start_o,
    output logic                            commit_o,
    input  logic                            calc_done_i,
    input  logic [servo_pkg::THRESH_W-1:0]  new_thresh_i
);

    localparam int BOOT_W = $clog2(servo_pkg::BOOT_CYCLES + 1);

    servo_pkg::servo_state_e         state;
    logic [BOOT_W-1:0]               boot_cnt;
    logic                            pending;    // Core transaction open
    logic                            issue;
    logic                            last_beam;
    logic                            nxt_we;
    logic [servo_pkg::ADDR_W-1:0]    nxt_adr;
    logic [servo_pkg::DATA_W-1:0]    nxt_dat;

    assign last_beam = (beam_idx_o == 8'(NBEAMS - 1));
    // Every state but BOOT and CALC is one bus step
    assign issue = !pending && (state != servo_pkg::BOOT) && (state != servo_pkg::CALC);

    assign count_wr_o   = (state == servo_pkg::READ_COUNTS) && done_i;
    assign count_o      = rd_data_i;
    assign calc_start_o = count_wr_o && last_beam;        // Last count in, start calc
    assign commit_o     = (state == servo_pkg::APPLY) && done_i;

    // Transaction for the current step
    always_comb begin
        nxt_we  = 1'b1;
        nxt_adr = servo_pkg::CORE_CMD_ADDR;
        nxt_dat = '0;
        case (state)
            servo_pkg::WRITE_THRESH: begin
                nxt_adr = servo_pkg::CORE_THRESH_BASE + servo_pkg::ADDR_W'(beam_idx_o);
                nxt_dat = servo_pkg::DATA_W'(new_thresh_i);
            end
            servo_pkg::ENABLE: begin
                nxt_adr = servo_pkg::CORE_CE_BASE + servo_pkg::ADDR_W'(beam_idx_o);
                nxt_dat = 32'd1;
            end
            servo_pkg::APPLY: nxt_dat = servo_pkg::CMD_APPLY;
            servo_pkg::POLL:  nxt_dat = servo_pkg::CMD_START_COUNT;
            servo_pkg::WAIT_DONE: nxt_we = 1'b0;            // Status read
            servo_pkg::READ_COUNTS: begin
                nxt_we  = 1'b0;
                nxt_adr = servo_pkg::CORE_THRESH_BASE + servo_pkg::ADDR_W'(beam_idx_o);
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control loop FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        req_o <= 1'b0;                                      // One-cycle strobe
        if (rst_i) begin
            state      <= servo_pkg::BOOT;
            boot_cnt   <= BOOT_W'(servo_pkg::BOOT_CYCLES - 1);
            pending    <= 1'b0;
            beam_idx_o <= '0;
        end else begin
            if (issue) begin
                req_o   <= 1'b1;
                pending <= 1'b1;
            end
            if (done_i) pending <= 1'b0;
            case (state)
                servo_pkg::BOOT:
                    if (boot_cnt == '0) state <= servo_pkg::WRITE_THRESH;
                    else boot_cnt <= boot_cnt - 1'b1;
                servo_pkg::WRITE_THRESH:
                    if (done_i) begin
                        beam_idx_o <= last_beam ? 8'd0 : beam_idx_o + 8'd1;
                        if (last_beam) state <= servo_pkg::ENABLE;
                    end
                servo_pkg::ENABLE:
                    if (done_i) begin
                        beam_idx_o <= last_beam ? 8'd0 : beam_idx_o + 8'd1;
                        if (last_beam) state <= servo_pkg::APPLY;
                    end
                servo_pkg::APPLY:     if (done_i) state <= servo_pkg::POLL;
                servo_pkg::POLL:      if (done_i) state <= servo_pkg::WAIT_DONE;
                servo_pkg::WAIT_DONE:
                    if (done_i && rd_data_i[0]) state <= servo_pkg::READ_COUNTS; // Else re-poll
                servo_pkg::READ_COUNTS:
                    if (done_i) begin
                        beam_idx_o <= last_beam ? 8'd0 : beam_idx_o + 8'd1;
                        if (last_beam) state <= servo_pkg::CALC;
                    end
                default:                                    // CALC
                    if (calc_done_i) state <= servo_pkg::WRITE_THRESH;
            endcase
        end
    end

    // Request payload
    always_ff @(posedge wb_clk_i) begin
        if (issue) begin
            req_we_o  <= nxt_we;
            req_adr_o <= nxt_adr;
            req_dat_o <= nxt_dat;
        end
    end

    // The master has to finish before the next request goes out
    one_outstanding: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        req_o |=> (!req_o until_with done_i));

endmodule

/* servo_loop/threshold_calc.sv */
`timescale 1ns/1ps

module threshold_calc #(
    parameter int NBEAMS       = 2,
    parameter int COUNT_MARGIN = 10
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  logic [7:0]                      beam_idx_i,
    input  logic                            count_wr_i,
    input  logic [servo_pkg::DATA_W-1:0]    count_i,
    input  logic                            calc_start_i,
    input  logic                            commit_i,
    input  logic [servo_pkg::DATA_W-1:0]    kp_i,
    input  logic [servo_pkg::DATA_W-1:0]    target_i,
    input  logic [7:0]                      rd_idx_i,
    output logic                            calc_done_o,
    output logic [servo_pkg::THRESH_W-1:0]  new_thresh_o,
    output logic [servo_pkg::DATA_W-1:0]    count_rd_o,
    output logic [servo_pkg::THRESH_W-1:0]  thresh_rd_o
);

    localparam int IDX_W = (NBEAMS > 1) ? $clog2(NBEAMS) : 1;
    localparam int XW    = servo_pkg::DATA_W + 1;               // Room for carry
    localparam logic [servo_pkg::THRESH_W-1:0] THRESH_MAX = '1;

    logic [servo_pkg::DATA_W-1:0]    count_q  [NBEAMS];         // Last measured counts
    logic [servo_pkg::THRESH_W-1:0]  thresh_q [NBEAMS];         // Applied in the core
    logic [servo_pkg::THRESH_W-1:0]  recalc_q [NBEAMS];         // Pending next apply
    logic                            walk_busy;
    logic [IDX_W-1:0]                walk_idx;
    logic [XW-1:0]                   hi_lim, lo_lim, walk_cnt, up_sum;
    logic [servo_pkg::THRESH_W-1:0]  walk_thr, next_thr;

    assign calc_done_o  = walk_busy && (walk_idx == IDX_W'(NBEAMS - 1));
    assign new_thresh_o = recalc_q[beam_idx_i[IDX_W-1:0]];
    assign count_rd_o   = count_q[rd_idx_i[IDX_W-1:0]];        // Range checked in slave
    assign thresh_rd_o  = thresh_q[rd_idx_i[IDX_W-1:0]];

    // Step rule for the beam being walked, clipped to the threshold range
    always_comb begin
        hi_lim   = {1'b0, target_i} + XW'(COUNT_MARGIN);
        lo_lim   = {1'b0, target_i} - XW'(COUNT_MARGIN);
        walk_cnt = {1'b0, count_q[walk_idx]};
        walk_thr = thresh_q[walk_idx];
        up_sum   = XW'(walk_thr) + {1'b0, kp_i};
        next_thr = walk_thr;
        if (walk_cnt > hi_lim)                                  // Rate high, raise
            next_thr = (up_sum > XW'(THRESH_MAX)) ? THRESH_MAX : up_sum[servo_pkg::THRESH_W-1:0];
        else if (target_i >= servo_pkg::DATA_W'(COUNT_MARGIN) && walk_cnt < lo_lim)
            next_thr = (kp_i > servo_pkg::DATA_W'(walk_thr)) ? '0 :
                       walk_thr - kp_i[servo_pkg::THRESH_W-1:0];
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            walk_busy <= 1'b0;
            walk_idx  <= '0;
            for (int i = 0; i < NBEAMS; i++) begin
                count_q[i]  <= '0;
                thresh_q[i] <= servo_pkg::START_THRESH;
                recalc_q[i] <= servo_pkg::START_THRESH;
            end
        end else begin
            if (count_wr_i) count_q[beam_idx_i[IDX_W-1:0]] <= count_i;
            if (calc_start_i) begin
                walk_busy <= 1'b1;
                walk_idx  <= '0;
            end else if (walk_busy) begin                       // One beam per cycle
                recalc_q[walk_idx] <= next_thr;
                walk_idx           <= walk_idx + 1'b1;
                if (calc_done_o) walk_busy <= 1'b0;
            end
            if (commit_i) thresh_q <= recalc_q;                 // Core has applied them
        end
    end

    count_idx_range: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        count_wr_i |-> beam_idx_i < NBEAMS);

endmodule

/* servo_loop/trig_bus_master.sv */
`timescale 1ns/1ps

module trig_bus_master (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  logic                            req_i,
    input  logic                            req_we_i,
    input  logic [servo_pkg::ADDR_W-1:0]    req_adr_i,
    input  logic [servo_pkg::DATA_W-1:0]    req_dat_i,
    output logic                            done_o,
    output logic [servo_pkg::DATA_W-1:0]    rd_data_o,
    output logic                            core_cyc_o,
    output logic                            core_stb_o,
    output logic                            core_we_o,
    output logic [servo_pkg::ADDR_W-1:0]    core_adr_o,
    output logic [servo_pkg::DATA_W-1:0]    core_dat_o,
    input  logic                            core_ack_i,
    input  logic [servo_pkg::DATA_W-1:0]    core_dat_i
);

    logic busy;                                   // Cycle open on the core bus

    assign core_cyc_o = busy;                     // cyc and stb move together
    assign core_stb_o = busy;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            busy   <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (req_i) begin
                busy <= 1'b1;
            end else if (busy && core_ack_i) begin
                busy   <= 1'b0;                   // Drop on the edge after ack
                done_o <= 1'b1;
            end
        end
    end

    // Address, data and read capture
    always_ff @(posedge wb_clk_i) begin
        if (req_i) begin
            core_we_o  <= req_we_i;
            core_adr_o <= req_adr_i;
            core_dat_o <= req_dat_i;
        end
        if (busy && core_ack_i) rd_data_o <= core_dat_i;
    end

    // Request held unchanged until the core acks
    hold_until_ack: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        core_stb_o && !core_ack_i |=>
            core_stb_o && $stable(core_adr_o) && $stable(core_dat_o) && $stable(core_we_o));

endmodule

/* tb/tb_rate_servo.sv */
`timescale 1ns/1ps

module tb_rate_servo;

    localparam int NBEAMS = 2;
    localparam int MARGIN = 10;
    localparam int PH_THR = 0, PH_CE = 1, PH_APPLY = 2, PH_START = 3, PH_STAT = 4, PH_CNT = 5;

    logic wb_clk_i, rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o, hold;
    logic [servo_pkg::ADDR_W-1:0] wb_adr_i, core_adr_o, exp_adr;
    logic [servo_pkg::DATA_W-1:0] wb_dat_i, wb_dat_o, core_dat_o, core_dat_i, exp_dat, exp_rd;
    logic core_cyc_o, core_stb_o, core_we_o, core_ack_i, exp_we;
    logic [servo_pkg::DATA_W-1:0] sh_kp, sh_target, cnt [NBEAMS];
    logic [servo_pkg::THRESH_W-1:0] next_thr [NBEAMS], written [NBEAMS], committed [NBEAMS];
    int phase, beam, n_apply, n_start;

    rate_servo_top #(.NBEAMS(NBEAMS), .COUNT_MARGIN(MARGIN), .START_TARGET(100), .START_KP(1))
    u_dut (.*);

    trig_core_model #(.NBEAMS(NBEAMS)) u_core (
        .wb_clk_i, .rst_i, .cyc_i(core_cyc_o), .stb_i(core_stb_o), .we_i(core_we_o),
        .adr_i(core_adr_o), .dat_i(core_dat_o), .ack_o(core_ack_i), .dat_o(core_dat_i),
        .hold_i(hold), .target_i(sh_target)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Some tests failed");
        $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
        $fatal(1);
    endtask

    task automatic fail_text(input string what);
        $display("Some tests failed");
        $display("at %0t: %s", $time, what);
        $fatal(1);
    endtask

    // Step rule, saturating at both ends of the 18-bit range
    function automatic logic [17:0] step_thresh(logic [17:0] thr, logic [31:0] c, logic [31:0] k,
                                                logic [31:0] g);
        longint t;
        t = thr;
        if (longint'(c) > longint'(g) + MARGIN) begin
            t = t + k;
            if (t > 262143) t = 262143;
        end else if (g >= MARGIN && longint'(c) < longint'(g) - MARGIN) begin
            t = t - k;
            if (t < 0) t = 0;
        end
        return t[17:0];
    endfunction

    // Expected core transaction for the current step
    always_comb begin
        exp_we  = 1'b1;
        exp_adr = servo_pkg::CORE_CMD_ADDR;
        exp_dat = '0;
        case (phase)
            PH_THR: begin
                exp_adr = servo_pkg::CORE_THRESH_BASE + 22'(beam);
                exp_dat = 32'(next_thr[beam]);
            end
            PH_CE:    {exp_adr, exp_dat} = {servo_pkg::CORE_CE_BASE + 22'(beam), 32'd1};
            PH_APPLY: exp_dat = servo_pkg::CMD_APPLY;
            PH_START: exp_dat = servo_pkg::CMD_START_COUNT;
            PH_STAT:  exp_we = 1'b0;
            default:  {exp_we, exp_adr} = {1'b0, servo_pkg::CORE_THRESH_BASE + 22'(beam)};
        endcase
    end

    always @(posedge wb_clk_i) begin : predictor
        logic [31:0] c_now [NBEAMS];
        if (rst_i) begin
            {phase, beam, n_apply, n_start} = '0;
            for (int i = 0; i < NBEAMS; i++) next_thr[i] = servo_pkg::START_THRESH;
        end else if (core_stb_o && core_ack_i) begin
            case (phase)
                PH_THR:   written[beam] = next_thr[beam];
                PH_APPLY: begin
                    committed = written;
                    n_apply++;
                end
                PH_START: n_start++;
                PH_CNT: begin
                    cnt[beam] = core_dat_i;
                    c_now = cnt;
                    if (beam == NBEAMS - 1)                  // All counts in, predict
                        for (int i = 0; i < NBEAMS; i++)
                            next_thr[i] = step_thresh(next_thr[i], c_now[i], sh_kp, sh_target);
                end
                default: ;
            endcase
            if (phase == PH_STAT) begin
                if (core_dat_i[0]) phase = PH_CNT;           // Window done
            end else if (phase == PH_THR || phase == PH_CE || phase == PH_CNT) begin
                beam = (beam == NBEAMS - 1) ? 0 : beam + 1;
                if (beam == 0) phase = (phase == PH_CNT) ? PH_THR : phase + 1;
            end else begin
                phase++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    quiet_reset: assert property (@(posedge wb_clk_i) rst_i |=> !core_cyc_o && !wb_ack_o)
        else fail_text("core_cyc_o or wb_ack_o high after a reset cycle");
    core_cyc: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        core_cyc_o == core_stb_o)
        else fail_text("core_cyc_o and core_stb_o do not move together");
    core_drop: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        core_stb_o && core_ack_i |=> !core_stb_o)
        else fail_text("core_stb_o still high on the cycle after the core ack");
    core_adr: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        core_stb_o && core_ack_i |-> core_adr_o == exp_adr)
        else fail_value("core_adr_o", $sampled(exp_adr), $sampled(core_adr_o));
    core_we: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        core_stb_o && core_ack_i |-> core_we_o == exp_we)
        else fail_value("core_we_o", $sampled(exp_we), $sampled(core_we_o));
    core_dat: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        core_stb_o && core_ack_i && exp_we |-> core_dat_o == exp_dat)
        else fail_value("core_dat_o", $sampled(exp_dat), $sampled(core_dat_o));
    sw_ack: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        wb_cyc_i && wb_stb_i && !$past(wb_cyc_i && wb_stb_i) |->
            !wb_ack_o ##1 !wb_ack_o ##1 wb_ack_o ##1 !wb_ack_o)
        else fail_text("wb_ack_o not a single pulse two cycles after the request");
    sw_rdata: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        wb_ack_o && !wb_we_i |-> wb_dat_o == exp_rd)
        else fail_value("wb_dat_o", $sampled(exp_rd), $sampled(wb_dat_o));

    task automatic sw_access(input logic we, input logic [21:0] adr, input logic [31:0] dat);
        int t;
        {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = {2'b11, we, adr, dat};
        for (t = 0; !wb_ack_o; t++) begin
            if (t > 8) fail_text("software access never acked");
            @(posedge wb_clk_i);
            #1;
        end
        {wb_cyc_i, wb_stb_i} = 2'b00;
        if (we && adr == 22'h0) sh_kp = dat;
        if (we && adr == 22'h4) sh_target = dat;
        @(posedge wb_clk_i);
        #1;
    endtask

    task automatic sw_read(input logic [21:0] adr, input logic [31:0] exp);
        exp_rd = exp;
        sw_access(1'b0, adr, '0);
    endtask

    task automatic wait_loop(input int which, input int n);
        for (int t = 0; (which ? n_start : n_apply) < n; t++) begin
            if (t > 2000) fail_text("servo loop stopped making progress");
            @(posedge wb_clk_i);
            #1;
        end
    endtask

    initial begin
        {rst_i, hold} = 2'b10;
        {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = '0;
        {sh_kp, sh_target, exp_rd} = {32'd1, 32'd100, 32'd0};
        repeat (2) @(posedge wb_clk_i);
        #1 rst_i = 1'b0;
        sw_access(1'b1, 22'h0, 32'd3);                      // Still in boot
        sw_access(1'b1, 22'h4, 32'd200);
        sw_read(22'h0, 32'd3);
        sw_read(22'h4, 32'd200);
        wait_loop(1, 2);                                     // Second window running
        sw_access(1'b1, 22'h0, 32'h0004_0000);               // Forces saturation
        wait_loop(0, 3);
        hold = 1'b1;                                         // Freeze counts for readback
        for (int i = 0; i < NBEAMS; i++) begin
            sw_read(servo_pkg::CORE_THRESH_BASE + 22'(i), cnt[i]);
            sw_read(servo_pkg::CORE_CE_BASE + 22'(i), 32'(committed[i]));
        end
        sw_read(servo_pkg::CORE_THRESH_BASE + 22'(NBEAMS), '0);
        sw_read(servo_pkg::CORE_CE_BASE + 22'(NBEAMS), '0);
        hold = 1'b0;
        wait_loop(0, 4);
        $display("All tests passed");
        $finish;
    end

endmodule

/* tb/trig_core_model.sv */
`timescale 1ns/1ps

module trig_core_model #(
    parameter int NBEAMS = 2
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_i,
    input  logic                            cyc_i,
    input  logic                            stb_i,
    input  logic                            we_i,
    input  logic [servo_pkg::ADDR_W-1:0]    adr_i,
    input  logic [servo_pkg::DATA_W-1:0]    dat_i,
    output logic                            ack_o,
    output logic [servo_pkg::DATA_W-1:0]    dat_o,
    input  logic                            hold_i,     // Withhold acks, stalls the loop
    input  logic [servo_pkg::DATA_W-1:0]    target_i
);

    integer                          seed = 32'h8c6c;
    logic                            armed;     // Latency count running
    logic [1:0]                      lat;       // Wait cycles drawn for this access
    logic [1:0]                      wait_cnt;
    logic [1:0]                      polls;     // Status reads in this window
    logic [servo_pkg::DATA_W-1:0]    off;

    // Answer of the core to the transaction being acked
    task automatic finish_access();
        ack_o <= 1'b1;
        dat_o <= '0;
        if (we_i) begin
            if (adr_i == servo_pkg::CORE_CMD_ADDR && dat_i == servo_pkg::CMD_START_COUNT)
                polls <= '0;                            // New window
        end else if (adr_i == servo_pkg::CORE_CMD_ADDR) begin
            dat_o <= {31'd0, polls == 2'd2};            // Done on third poll
            polls <= polls + 2'd1;
        end else begin
            off = {$random(seed)} % 40;
            // Even beams run hot, odd beams run cold
            dat_o <= adr_i[0] ? target_i - off : target_i + off;
        end
    endtask

    always @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            armed <= 1'b0;
            polls <= '0;
        end else begin
            ack_o <= 1'b0;
            if (cyc_i && stb_i && !ack_o && !hold_i) begin
                if (!armed) begin
                    lat = 2'({$random(seed)} % 4);      // 0 to 3 wait cycles
                    if (lat == 2'd0) begin
                        finish_access();
                    end else begin
                        armed    <= 1'b1;
                        wait_cnt <= lat - 2'd1;
                    end
                end else if (wait_cnt == 2'd0) begin
                    armed <= 1'b0;
                    finish_access();
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule
